// File: build.f
src/tomasulo_pkg.sv
src/issue_unit.sv
src/reg_status.sv
src/res_station.sv
src/exec_unit.sv
src/cdb_arbiter.sv
src/tomasulo_core.sv
sim/tomasulo_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the Tomasulo core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f build.f --top-module tomasulo_core_tb -o sim_tomasulo
out=$(./obj_dir/sim_tomasulo)
echo "$out"
if echo "$out" | grep -q "All checks passed"; then
  exit 0
fi
exit 1

// File: sim/tomasulo_core_tb.sv
`default_nettype none

module tomasulo_core_tb import tomasulo_pkg::*; ();

  localparam string             TESTS_FILE   = "sim/tomasulo_tests.txt";
  localparam logic [DATA_W-1:0] RESET_VAL    = 32'd5;
  localparam inst_t             AFTER_HALT   = 32'h2fff_0000;  // mul r15, r15, r15
  localparam int                QUIET_CYCLES = 20;

  logic              GCLK = 1'b0;
  logic              rst;
  inst_t             inst;
  logic              inst_valid;
  logic              fetch_en;
  cdb_t              cdb;
  reg_idx_t          dbg_addr;
  logic [DATA_W-1:0] dbg_data;
  logic              dbg_pending;

  inst_t       inst_q  [$];  // All programs back to back
  logic [31:0] exp_q   [$];  // NUM_REGS expected values per program
  int          first_q [$];  // First instruction of each program
  int          len_q   [$];
  int          stall_q [$];  // Stations must fill at least once

  int   err_cnt;
  int   fail_cnt;
  int   limit;
  logic limit_set  = 1'b0;
  logic halt_taken = 1'b0;
  int   cycles      = 0;
  int   cdb_total   = 0;  // Broadcast cycles since time zero
  int   stall_total = 0;  // Cycles with fetch off before a halt

  tomasulo_core #(.ADD_LAT(2), .MUL_LAT(4), .REG_INIT(RESET_VAL)) uut (
    .GCLK, .rst, .inst, .inst_valid, .fetch_en, .cdb, .dbg_addr, .dbg_data, .dbg_pending
  );

  always #10 GCLK = ~GCLK;

  always @(posedge GCLK) cycles <= cycles + 1;

  // Bus and stall activity, sampled away from the rising edge
  always @(negedge GCLK) begin
    if (!rst && cdb.valid) cdb_total <= cdb_total + 1;
    if (!rst && !halt_taken && !fetch_en) stall_total <= stall_total + 1;
  end

  initial begin
    wait (limit_set);
    while (cycles < limit) @(posedge GCLK);
    $display("Timeout: the run went past its limit of %0d cycles", limit);
    $display("Checks failed");
    $finish;
  end

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      err_cnt++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
    end
  endtask

  // P starts a program, I adds an instruction, X sets an expected register
  task automatic read_tests();
    int          fd;
    int          n;
    int          want;  // Fields a well-formed line yields
    int          idx;
    int          flag;
    logic [31:0] word;
    string       line;
    fd = $fopen(TESTS_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the tests file %s", TESTS_FILE);
      fail_cnt++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      n    = 0;
      want = 0;
      case (line[0])
        "P": begin
          n    = $sscanf(line, "P %d", flag);
          want = 1;
          first_q.push_back(inst_q.size());
          len_q.push_back(0);
          stall_q.push_back(flag);
          for (int i = 0; i < NUM_REGS; i++) exp_q.push_back(RESET_VAL); // Untouched regs
        end
        "I": begin
          n    = $sscanf(line, "I %h", word);
          want = 1;
          inst_q.push_back(inst_t'(word));
          len_q[len_q.size() - 1]++;
        end
        "X": begin
          n    = $sscanf(line, "X %d %h", idx, word);
          want = 2;
          exp_q[NUM_REGS * (len_q.size() - 1) + idx] = word;
        end
        default: ;  // Comments and blank lines
      endcase
      if (n != want) begin
        $display("Malformed line in the tests file: %s", line);
        fail_cnt++;
      end
    end
    $fclose(fd);
  endtask

  // Called just after a rising edge, returns on the edge that takes it
  task automatic send_inst(input inst_t w);
    inst       <= w;
    inst_valid <= 1'b1;
    @(negedge GCLK);
    while (!fetch_en) @(negedge GCLK);  // Held while all stations are full
    @(posedge GCLK);
  endtask

  task automatic scan_pending(output logic found);
    found = 1'b0;
    for (int i = 0; i < NUM_REGS; i++) begin
      @(posedge GCLK);
      dbg_addr <= reg_idx_t'(i);
      @(negedge GCLK);
      if (dbg_pending) found = 1'b1;
    end
  endtask

  task automatic check_regs(input int base, input logic after_reset);
    logic [31:0] exp_v;
    for (int i = 0; i < NUM_REGS; i++) begin
      @(posedge GCLK);
      dbg_addr <= reg_idx_t'(i);
      @(negedge GCLK);
      exp_v = after_reset ? RESET_VAL : exp_q[base + i];
      check_val($sformatf("r%0d dbg_pending", i), 32'd0, 32'(dbg_pending));
      check_val($sformatf("r%0d dbg_data", i), exp_v, dbg_data);
    end
  endtask

  task automatic run_program(input int p);
    int   cdb_start;
    int   stall_start;
    int   n_ops;
    int   quiet;
    logic busy_regs;
    @(posedge GCLK);
    rst        <= 1'b1;
    inst_valid <= 1'b0;
    halt_taken = 1'b0;
    repeat (16) @(posedge GCLK);
    rst <= 1'b0;
    @(negedge GCLK);
    check_val("fetch_en", 32'd1, 32'(fetch_en));
    check_val("cdb.valid", 32'd0, 32'(cdb.valid));
    check_regs(0, 1'b1);
    @(posedge GCLK);
    cdb_start   = cdb_total;
    stall_start = stall_total;
    n_ops       = 0;
    for (int k = first_q[p]; k < first_q[p] + len_q[p]; k++) begin
      send_inst(inst_q[k]);
      if (inst_q[k].opcode == OP_HLT) break;
      n_ops++;
    end
    halt_taken = 1'b1;
    inst       <= AFTER_HALT;  // Stays on the port, must never be taken
    inst_valid <= 1'b1;
    busy_regs = 1'b1;
    while (busy_regs) begin
      quiet = 0;
      while (quiet < QUIET_CYCLES) begin
        @(negedge GCLK);
        check_val("fetch_en", 32'd0, 32'(fetch_en));
        if (cdb.valid) quiet = 0;
        else quiet++;
      end
      scan_pending(busy_regs);
    end
    check_regs(NUM_REGS * p, 1'b0);
    check_val("cdb.valid count", n_ops, cdb_total - cdb_start);
    if (stall_q[p] != 0 && stall_total == stall_start) begin
      $display("Program %0d: fetch_en never went low although all stations should fill", p);
      fail_cnt++;
    end
  endtask

  initial begin
    err_cnt    = 0;
    fail_cnt   = 0;
    rst        <= 1'b1;
    inst       <= '0;
    inst_valid <= 1'b0;
    dbg_addr   <= '0;
    read_tests();
    if (len_q.size() == 0) begin
      $display("No programs were read from %s", TESTS_FILE);
      fail_cnt++;
    end
    limit = 100;
    foreach (len_q[p]) limit += 40 * len_q[p] + 100;
    limit_set = 1'b1;
    for (int p = 0; p < len_q.size(); p++) run_program(p);
    $display("Errors: %0d value mismatches, %0d other failures", err_cnt, fail_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/tomasulo_tests.txt
# P <1 if fetch must stall>, I <instruction hex>, X <register> <final value hex>
# Registers without an X line keep their reset value of 5
# Independent add, sub and mul, low 16 bits ignored
P 0
I 01230000
I 14560000
I 2789abcd
I f0000000
X 1 0000000a
X 4 00000000
X 7 00000019
# Read-after-write chain with repeated writes to r5
P 0
I 05120000
I 26550000
I 15650000
I 07560000
I 15370000
I 28560000
I f0000000
X 5 ffffff47
X 6 00000064
X 7 000000be
X 8 ffffb7bc
# Six dependent multiplies fill every station
P 1
I 21120000
I 22110000
I 23210000
I 24330000
I 25410000
I 26520000
I f0000000
X 1 00000019
X 2 00000271
X 3 00003d09
X 4 0e8d4a51
X 5 6bcc41e9
X 6 2dace9d9

// File: src/cdb_arbiter.sv
`default_nettype none

module cdb_arbiter import tomasulo_pkg::*; (
  input  logic GCLK,
  input  logic rst,
  input  logic add_done,
  input  logic mul_done,
  input  cdb_t add_result,
  input  cdb_t mul_result,
  output logic add_grant,
  output logic mul_grant,
  output cdb_t cdb
);

  // Fixed priority, the longer unit goes first
  assign mul_grant = mul_done;
  assign add_grant = add_done && !mul_done;  // Add waits a cycle on a tie

  always_ff @(posedge GCLK) begin
    if (rst) begin
      cdb <= '0;
    end else if (mul_grant) begin
      cdb <= mul_result;
    end else if (add_grant) begin
      cdb <= add_result;
    end else begin
      cdb.valid <= 1'b0;  // One-cycle broadcast
    end
  end

endmodule

`default_nettype wire

// File: src/exec_unit.sv
`default_nettype none

module exec_unit import tomasulo_pkg::*; #(
  parameter fu_kind_t KIND    = FU_ADD,
  parameter int       LATENCY = 2  // Cycles from dispatch to done, at least 1
) (
  input  logic   GCLK,
  input  logic   rst,
  input  issue_t disp,
  output logic   busy,
  output logic   done,
  output cdb_t   result,
  input  logic   grant
);

  localparam int CNT_W = (LATENCY > 1) ? $clog2(LATENCY) : 1;

  logic [CNT_W-1:0]  cnt;
  logic [DATA_W-1:0] a_q, b_q;   // Latched operands
  logic [DATA_W-1:0] value_q;
  opcode_t           op_q;
  rs_tag_t           tag_q;
  logic              start;

  assign start = disp.valid && !busy;

  always_ff @(posedge GCLK) begin
    if (start) begin
      a_q   <= disp.a.value;
      b_q   <= disp.b.value;
      op_q  <= disp.op;
      tag_q <= disp.tag;
    end
    if (busy && !done && cnt == '0) begin
      if (KIND == FU_MUL) value_q <= a_q * b_q;  // Low word of the product
      else value_q <= (op_q == OP_SUB) ? a_q - b_q : a_q + b_q;
    end
  end

  always_ff @(posedge GCLK) begin
    if (rst) begin
      busy <= 1'b0;
      done <= 1'b0;
      cnt  <= '0;
    end else if (start) begin
      busy <= 1'b1;
      cnt  <= CNT_W'(LATENCY - 1);
    end else if (done && grant) begin
      done <= 1'b0;  // Result moves onto the bus
      busy <= 1'b0;
    end else if (busy && !done) begin
      if (cnt == '0) done <= 1'b1;
      else cnt <= cnt - CNT_W'(1);
    end
  end

  assign result = '{valid: done, tag: tag_q, value: value_q};

endmodule

`default_nettype wire

// File: src/issue_unit.sv
`default_nettype none

module issue_unit import tomasulo_pkg::*; (
  input  logic              GCLK,
  input  logic              rst,
  input  inst_t             inst,
  input  logic              inst_valid,
  input  logic [NUM_RS-1:0] rs_free,
  input  operand_t          src_a,       // Already bypassed with the bus
  input  operand_t          src_b,
  output logic              fetch_en,
  output issue_t            issue,
  output logic              rename_valid,
  output reg_idx_t          rename_dst,
  output reg_idx_t          src1,
  output reg_idx_t          src2
);

  logic    halted;   // Sticky until reset
  logic    take;     // Instruction accepted this cycle
  rs_tag_t free_idx; // Lowest free station

  assign fetch_en = (|rs_free) && !halted;
  assign take     = inst_valid && fetch_en;
  assign src1     = inst.src1;
  assign src2     = inst.src2;

  // Priority pick, station 0 first
  always_comb begin
    free_idx = '0;
    for (int i = NUM_RS - 1; i >= 0; i--) begin
      if (rs_free[i]) free_idx = rs_tag_t'(i);
    end
  end

  always_comb begin
    issue.valid = take && (inst.opcode != OP_HLT); // Halt never occupies a station
    issue.tag   = free_idx;
    issue.op    = inst.opcode;
    issue.a     = src_a;
    issue.b     = src_b;
  end

  assign rename_valid = issue.valid;  // Destination renamed on the issue edge
  assign rename_dst   = inst.dst;

  always_ff @(posedge GCLK) begin
    if (rst) begin
      halted <= 1'b0;
    end else if (take && inst.opcode == OP_HLT) begin
      halted <= 1'b1;  // Fetch stays off from here on
    end
  end

endmodule

`default_nettype wire

// File: src/reg_status.sv
`default_nettype none

module reg_status import tomasulo_pkg::*; #(
  parameter logic [DATA_W-1:0] REG_INIT = 32'd5
) (
  input  logic              GCLK,
  input  logic              rst,
  input  reg_idx_t          src1,
  input  reg_idx_t          src2,
  output operand_t          src_a,
  output operand_t          src_b,
  input  logic              rename_valid,
  input  reg_idx_t          rename_dst,
  input  rs_tag_t           rename_tag,
  input  cdb_t              cdb,
  input  reg_idx_t          dbg_addr,
  output logic [DATA_W-1:0] dbg_data,
  output logic              dbg_pending
);

  logic [DATA_W-1:0] val_q  [NUM_REGS];
  logic              pend_q [NUM_REGS];  // Waiting on a station
  rs_tag_t           tag_q  [NUM_REGS];  // Producer of the pending value

  // Register read with bypass from the broadcast in flight
  function automatic operand_t lookup(input reg_idx_t idx);
    operand_t op;
    op.pending = pend_q[idx];
    op.tag     = tag_q[idx];
    op.value   = val_q[idx];
    if (pend_q[idx] && cdb.valid && cdb.tag == tag_q[idx]) begin
      op.pending = 1'b0;       // Result arrives this cycle
      op.value   = cdb.value;
    end
    return op;
  endfunction

  always_comb begin
    src_a = lookup(src1);
    src_b = lookup(src2);
  end

  always_ff @(posedge GCLK) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        val_q[i]  <= REG_INIT;
        pend_q[i] <= 1'b0;
        tag_q[i]  <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_REGS; i++) begin
        if (rename_valid && rename_dst == reg_idx_t'(i)) begin
          pend_q[i] <= 1'b1;       // Latest rename wins over the bus
          tag_q[i]  <= rename_tag;
        end else if (cdb.valid && pend_q[i] && tag_q[i] == cdb.tag) begin
          val_q[i]  <= cdb.value;
          pend_q[i] <= 1'b0;
        end
      end
    end
  end

  assign dbg_data    = val_q[dbg_addr];
  assign dbg_pending = pend_q[dbg_addr];

endmodule

`default_nettype wire

// File: src/res_station.sv
`default_nettype none

module res_station import tomasulo_pkg::*; (
  input  logic              GCLK,
  input  logic              rst,
  input  issue_t            issue,
  input  cdb_t              cdb,
  output logic [NUM_RS-1:0] rs_free,
  input  logic              add_busy,
  input  logic              mul_busy,
  output issue_t            add_disp,
  output issue_t            mul_disp
);

  issue_t            ent [NUM_RS];  // Stored instruction and operands
  logic [NUM_RS-1:0] busy_q;        // Held until own tag is broadcast
  logic [NUM_RS-1:0] disp_q;        // Already sent to a unit
  logic [NUM_RS-1:0] ready;
  logic              add_hit;
  logic              mul_hit;
  rs_tag_t           add_idx;
  rs_tag_t           mul_idx;

  assign rs_free = ~busy_q;

  always_comb begin
    for (int i = 0; i < NUM_RS; i++) begin
      ready[i] = busy_q[i] && !disp_q[i] && !ent[i].a.pending && !ent[i].b.pending;
    end
  end

  // Lowest ready station per unit
  // Anything that is not a multiply goes to the add unit
  always_comb begin
    add_hit = 1'b0;
    mul_hit = 1'b0;
    add_idx = '0;
    mul_idx = '0;
    for (int i = NUM_RS - 1; i >= 0; i--) begin
      if (ready[i] && ent[i].op == OP_MUL) begin
        mul_hit = 1'b1;
        mul_idx = rs_tag_t'(i);
      end
      if (ready[i] && ent[i].op != OP_MUL) begin
        add_hit = 1'b1;
        add_idx = rs_tag_t'(i);
      end
    end
  end

  always_comb begin
    add_disp       = ent[add_idx];
    add_disp.valid = add_hit && !add_busy;  // Offer only to an idle unit
    add_disp.tag   = add_idx;
    mul_disp       = ent[mul_idx];
    mul_disp.valid = mul_hit && !mul_busy;
    mul_disp.tag   = mul_idx;
  end

  // Operand payload, filled at issue and patched from the bus
  always_ff @(posedge GCLK) begin
    for (int i = 0; i < NUM_RS; i++) begin
      if (issue.valid && issue.tag == rs_tag_t'(i)) begin
        ent[i] <= issue;
      end else begin
        if (cdb.valid && ent[i].a.pending && ent[i].a.tag == cdb.tag) begin
          ent[i].a.pending <= 1'b0;
          ent[i].a.value   <= cdb.value;
        end
        if (cdb.valid && ent[i].b.pending && ent[i].b.tag == cdb.tag) begin
          ent[i].b.pending <= 1'b0;
          ent[i].b.value   <= cdb.value;
        end
      end
    end
  end

  always_ff @(posedge GCLK) begin
    if (rst) begin
      busy_q <= '0;
      disp_q <= '0;
    end else begin
      for (int i = 0; i < NUM_RS; i++) begin
        if (issue.valid && issue.tag == rs_tag_t'(i)) begin
          busy_q[i] <= 1'b1;
          disp_q[i] <= 1'b0;
        end else begin
          if (cdb.valid && cdb.tag == rs_tag_t'(i)) busy_q[i] <= 1'b0; // Result is out
          if ((add_disp.valid && add_idx == rs_tag_t'(i)) ||
              (mul_disp.valid && mul_idx == rs_tag_t'(i))) begin
            disp_q[i] <= 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/tomasulo_core.sv
`default_nettype none

module tomasulo_core import tomasulo_pkg::*; #(
  parameter int                ADD_LAT  = 2,
  parameter int                MUL_LAT  = 4,
  parameter logic [DATA_W-1:0] REG_INIT = 32'd5
) (
  input  logic              GCLK,
  input  logic              rst,
  input  inst_t             inst,
  input  logic              inst_valid,
  output logic              fetch_en,
  output cdb_t              cdb,
  input  reg_idx_t          dbg_addr,
  output logic [DATA_W-1:0] dbg_data,
  output logic              dbg_pending
);

  logic [NUM_RS-1:0] rs_free;
  operand_t          src_a, src_b;
  reg_idx_t          src1, src2;
  issue_t            issue;
  logic              rename_valid;
  reg_idx_t          rename_dst;
  issue_t            add_disp, mul_disp;
  logic              add_busy, mul_busy;
  logic              add_done, mul_done;
  cdb_t              add_result, mul_result;
  logic              add_grant, mul_grant;

  issue_unit u_issue (
    .GCLK, .rst, .inst, .inst_valid, .rs_free, .src_a, .src_b,
    .fetch_en, .issue, .rename_valid, .rename_dst, .src1, .src2
  );

  reg_status #(.REG_INIT(REG_INIT)) u_regs (
    .GCLK, .rst, .src1, .src2, .src_a, .src_b, .rename_valid, .rename_dst,
    .rename_tag(issue.tag),  // New producer is the station just filled
    .cdb, .dbg_addr, .dbg_data, .dbg_pending
  );

  res_station u_rs (
    .GCLK, .rst, .issue, .cdb, .rs_free, .add_busy, .mul_busy, .add_disp, .mul_disp
  );

  exec_unit #(.KIND(FU_ADD), .LATENCY(ADD_LAT)) u_add (
    .GCLK, .rst, .disp(add_disp), .busy(add_busy), .done(add_done),
    .result(add_result), .grant(add_grant)
  );

  exec_unit #(.KIND(FU_MUL), .LATENCY(MUL_LAT)) u_mul (
    .GCLK, .rst, .disp(mul_disp), .busy(mul_busy), .done(mul_done),
    .result(mul_result), .grant(mul_grant)
  );

  cdb_arbiter u_cdb (
    .GCLK, .rst, .add_done, .mul_done, .add_result, .mul_result,
    .add_grant, .mul_grant, .cdb
  );

endmodule

`default_nettype wire

// File: src/tomasulo_pkg.sv
`default_nettype none

package tomasulo_pkg;

  localparam int DATA_W   = 32;  // Register and operand width
  localparam int NUM_REGS = 16;
  localparam int NUM_RS   = 4;   // Reservation stations, also the tag space

  typedef logic [3:0] reg_idx_t;
  typedef logic [1:0] rs_tag_t;  // Station id doubles as producer tag

  typedef enum logic [3:0] {
    OP_ADD = 4'h0,
    OP_SUB = 4'h1,
    OP_MUL = 4'h2,
    OP_HLT = 4'hf
  } opcode_t;

  // Operation class of a functional unit
  typedef enum logic {
    FU_ADD = 1'b0,  // Add and sub
    FU_MUL = 1'b1
  } fu_kind_t;

  // Instruction word, opcode in the top nibble
  typedef struct packed {
    opcode_t     opcode;
    reg_idx_t    dst;
    reg_idx_t    src1;
    reg_idx_t    src2;
    logic [15:0] unused;
  } inst_t;

  // Source operand, either a value or the tag of its producer
  typedef struct packed {
    logic              pending;
    rs_tag_t           tag;
    logic [DATA_W-1:0] value;
  } operand_t;

  typedef struct packed {
    logic              valid;
    rs_tag_t           tag;
    logic [DATA_W-1:0] value;
  } cdb_t;

  typedef struct packed {
    logic     valid;
    rs_tag_t  tag;  // Station that holds the instruction
    opcode_t  op;
    operand_t a;
    operand_t b;
  } issue_t;

endpackage

`default_nettype wire
